/* hw/vmem_pkg.sv */
// Shared lane count, word type and encodings for the vector memory unit; imported by every block
package vmem_pkg;

    localparam int NUM_LANES = 4;          // Vector lanes per micro-op
    localparam int LANE_W    = 2;          // Bits to name one lane
    localparam int UOP_W     = 8;          // Micro-op number width
    localparam int BYTES_W   = 4;          // Bytes per data word

    // Data or address word
    typedef logic [31:0] word_t;

    // Lane index
    typedef logic [LANE_W-1:0] lane_t;

    // Element width of a vector memory micro-op
    typedef enum logic [1:0] {
        SEW8  = 2'd0,
        SEW16 = 2'd1,
        SEW32 = 2'd2
    } sew_t;

    // Access size seen by the load/store controller
    typedef enum logic [1:0] {
        LB = 2'd0,
        LH = 2'd1,
        LW = 2'd2
    } load_type_t;

    // Lane currently being served by the serializer
    typedef enum logic [LANE_W-1:0] {
        VL0 = 2'd0,
        VL1 = 2'd1,
        VL2 = 2'd2,
        VL3 = 2'd3
    } serial_state_t;

endpackage

/* hw/vmem_serial_if.sv */
// Operand and lane-progress signals between the sequencer and the serializer
`timescale 1ns/1ps

interface vmem_serial_if;

    import vmem_pkg::*;

    // Driven by the sequencer
    logic                       vmemdren;    // Read micro-op in progress
    logic                       vmemdwen;    // Write micro-op in progress
    logic                       vindexed;
    logic [UOP_W-1:0]           uop_num;
    word_t                      base;
    word_t                      stride;
    word_t [NUM_LANES-1:0]      lane_addr;   // Base plus index, indexed mode only
    logic [NUM_LANES-1:0]       lane_mask;
    sew_t                       veew;
    word_t [NUM_LANES-1:0]      store_data;

    // Driven by the serializer
    logic                       lane_done;   // Lane advances this cycle
    lane_t                      vcurr_lane;
    logic                       last_lane;   // lane_done in VL3
    word_t                      vload_data;  // Extracted element of the current lane

    modport seq (
        output vmemdren, vmemdwen, vindexed, uop_num, base, stride,
        output lane_addr, lane_mask, veew, store_data,
        input  lane_done, vcurr_lane, last_lane, vload_data
    );

    modport serial (
        input  vmemdren, vmemdwen, vindexed, uop_num, base, stride,
        input  lane_addr, lane_mask, veew, store_data,
        output lane_done, vcurr_lane, last_lane, vload_data
    );

endinterface

/* hw/vmem_lsc_if.sv */
// Single-element access channel from the serializer to the load/store controller
`timescale 1ns/1ps

interface vmem_lsc_if;

    import vmem_pkg::*;

    // Held by the serializer until lsc_ready
    word_t      vaddr_lsc;
    logic       vmemdren_lsc;
    logic       vmemdwen_lsc;
    word_t      vdata_store_lsc;
    load_type_t vload_type;

    // Returned by the controller
    logic       lsc_ready;      // Access completes this cycle
    word_t      load_data;      // Zero-extended element, valid with lsc_ready

    modport serial (
        output vaddr_lsc, vmemdren_lsc, vmemdwen_lsc, vdata_store_lsc, vload_type,
        input  lsc_ready, load_data
    );

    modport lsc (
        input  vaddr_lsc, vmemdren_lsc, vmemdwen_lsc, vdata_store_lsc, vload_type,
        output lsc_ready, load_data
    );

endinterface

/* hw/vmem_sequencer.sv */
// Accepts vector memory micro-ops, holds their operands and gathers the four-lane response
`timescale 1ns/1ps

module vmem_sequencer (
    input  logic                                         CLK,
    input  logic                                         nRST,
    input  logic                                         req_valid,
    output logic                                         req_ready,
    input  logic                                         req_store,
    input  logic                                         req_indexed,
    input  logic [vmem_pkg::UOP_W-1:0]                   req_uop_num,
    input  vmem_pkg::word_t                              req_base,
    input  vmem_pkg::word_t                              req_stride,
    input  vmem_pkg::word_t [vmem_pkg::NUM_LANES-1:0]    req_index,
    input  logic [vmem_pkg::NUM_LANES-1:0]               req_mask,
    input  vmem_pkg::sew_t                               req_eew,
    input  vmem_pkg::word_t [vmem_pkg::NUM_LANES-1:0]    req_store_data,
    output logic                                         resp_valid,
    output vmem_pkg::word_t [vmem_pkg::NUM_LANES-1:0]    resp_load_data,
    vmem_serial_if.seq                                   serial_if
);

    import vmem_pkg::*;

    typedef enum logic {
        SEQ_IDLE,
        SEQ_BUSY
    } seq_state_t;

    seq_state_t             state;
    logic                   store_q;
    logic                   accept;
    word_t [NUM_LANES-1:0]  result_q;

    assign req_ready = (state == SEQ_IDLE);
    assign accept    = req_valid & req_ready;

    // Enables stay up for the whole micro-op, the serializer gates them per lane
    assign serial_if.vmemdren = (state == SEQ_BUSY) & ~store_q;
    assign serial_if.vmemdwen = (state == SEQ_BUSY) & store_q;

    assign resp_load_data = result_q;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state              <= SEQ_IDLE;
            resp_valid         <= 1'b0;
            store_q            <= 1'b0;
            serial_if.vindexed <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (accept) begin
                        state              <= SEQ_BUSY;
                        store_q            <= req_store;
                        serial_if.vindexed <= req_indexed;
                    end
                end
                SEQ_BUSY: begin
                    if (serial_if.last_lane) begin
                        state      <= SEQ_IDLE;
                        resp_valid <= 1'b1;   // Same cycle as req_ready rising
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // Operands and per-lane results
    always_ff @(posedge CLK) begin
        if (accept) begin
            serial_if.uop_num    <= req_uop_num;
            serial_if.base       <= req_base;
            serial_if.stride     <= req_stride;
            serial_if.lane_mask  <= req_mask;
            serial_if.veew       <= req_eew;
            serial_if.store_data <= req_store_data;
            for (int i = 0; i < NUM_LANES; i++) begin
                serial_if.lane_addr[i] <= req_base + req_index[i];
                result_q[i]            <= '0;   // Masked lanes and stores return zero
            end
        end else if (serial_if.lane_done && !store_q &&
                     serial_if.lane_mask[serial_if.vcurr_lane]) begin
            result_q[serial_if.vcurr_lane] <= serial_if.vload_data;
        end
    end

endmodule

/* hw/vmem_serializer.sv */
// Steps a micro-op through its lanes and issues one element access per active lane
`timescale 1ns/1ps

module vmem_serializer (
    input  logic            CLK,
    input  logic            nRST,
    vmem_serial_if.serial   serial_if,
    vmem_lsc_if.serial      lsc_if
);

    import vmem_pkg::*;

    serial_state_t  serial_state;
    serial_state_t  next_serial_state;
    word_t          run_addr;        // Address of the current strided lane
    word_t          next_run_addr;
    lane_t          cur_lane;
    logic           active;
    logic           first_elem;      // Lane 0 of micro-op zero
    logic           lane_masked;
    logic           lane_step;

    assign cur_lane    = lane_t'(serial_state);
    assign active      = serial_if.vmemdren | serial_if.vmemdwen;
    assign first_elem  = (serial_if.uop_num == '0) && (serial_state == VL0);
    assign lane_masked = ~serial_if.lane_mask[cur_lane];

    // Masked lanes never wait on the controller
    assign lane_step = active & (lsc_if.lsc_ready | lane_masked);

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            serial_state <= VL0;
            run_addr     <= '0;
        end else begin
            serial_state <= next_serial_state;
            run_addr     <= next_run_addr;
        end
    end

    always_comb begin
        next_serial_state = serial_state;
        next_run_addr     = run_addr;

        if (!active) begin
            next_serial_state = VL0;
        end else if (lane_step) begin
            // Strided address carries over into the next micro-op
            if (first_elem) begin
                next_run_addr = serial_if.base + serial_if.stride;
            end else begin
                next_run_addr = run_addr + serial_if.stride;
            end

            case (serial_state)
                VL0:     next_serial_state = VL1;
                VL1:     next_serial_state = VL2;
                VL2:     next_serial_state = VL3;
                VL3:     next_serial_state = VL0;
                default: next_serial_state = VL0;
            endcase
        end
    end

    // Element address
    always_comb begin
        if (serial_if.vindexed) begin
            lsc_if.vaddr_lsc = serial_if.lane_addr[cur_lane];
        end else if (first_elem) begin
            lsc_if.vaddr_lsc = serial_if.base;
        end else begin
            lsc_if.vaddr_lsc = run_addr;
        end
    end

    always_comb begin
        case (serial_if.veew)
            SEW8:    lsc_if.vload_type = LB;
            SEW16:   lsc_if.vload_type = LH;
            SEW32:   lsc_if.vload_type = LW;
            default: lsc_if.vload_type = LW;
        endcase
    end

    assign lsc_if.vmemdren_lsc    = serial_if.vmemdren & ~lane_masked;
    assign lsc_if.vmemdwen_lsc    = serial_if.vmemdwen & ~lane_masked;
    assign lsc_if.vdata_store_lsc = serial_if.store_data[cur_lane];

    assign serial_if.lane_done  = lane_step;
    assign serial_if.vcurr_lane = cur_lane;
    assign serial_if.last_lane  = lane_step & (serial_state == VL3);
    assign serial_if.vload_data = lsc_if.load_data;

endmodule

/* hw/vmem_lsc.sv */
// Load/store controller that maps one element access onto the word-wide data port
`timescale 1ns/1ps

module vmem_lsc (
    input  logic                            CLK,
    input  logic                            nRST,
    vmem_lsc_if.lsc                         lsc_if,
    output logic                            mem_req,
    output logic                            mem_wen,
    output vmem_pkg::word_t                 mem_addr,
    output logic [vmem_pkg::BYTES_W-1:0]    mem_byte_en,
    output vmem_pkg::word_t                 mem_wdata,
    input  vmem_pkg::word_t                 mem_rdata,
    input  logic                            mem_ready
);

    import vmem_pkg::*;

    logic [1:0]     byte_off;
    logic           busy;            // Request left waiting last cycle
    logic           new_req;
    word_t          held_addr;
    logic           held_wen;
    word_t          rdata_shift;

    assign byte_off = lsc_if.vaddr_lsc[1:0];

    assign mem_req  = lsc_if.vmemdren_lsc | lsc_if.vmemdwen_lsc;
    assign mem_wen  = lsc_if.vmemdwen_lsc;
    assign mem_addr = {lsc_if.vaddr_lsc[31:2], 2'b00};   // Word aligned
    assign new_req  = mem_req & ~busy;

    assign lsc_if.lsc_ready = mem_req & mem_ready;

    // Byte lanes and store placement, accesses are naturally aligned
    always_comb begin
        case (lsc_if.vload_type)
            LB: begin
                mem_byte_en = 4'b0001 << byte_off;
                mem_wdata   = {4{lsc_if.vdata_store_lsc[7:0]}};
            end
            LH: begin
                mem_byte_en = 4'b0011 << byte_off;
                mem_wdata   = {2{lsc_if.vdata_store_lsc[15:0]}};
            end
            default: begin
                mem_byte_en = 4'b1111;
                mem_wdata   = lsc_if.vdata_store_lsc;
            end
        endcase
    end

    assign rdata_shift = mem_rdata >> {byte_off, 3'b000};

    always_comb begin
        case (lsc_if.vload_type)
            LB:      lsc_if.load_data = {24'h0, rdata_shift[7:0]};
            LH:      lsc_if.load_data = {16'h0, rdata_shift[15:0]};
            default: lsc_if.load_data = mem_rdata;
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            busy <= 1'b0;
        end else begin
            busy <= mem_req & ~mem_ready;
        end
    end

    // A waiting request must keep its address and direction
    always_ff @(posedge CLK) begin
        if (new_req) begin
            held_addr <= mem_addr;
            held_wen  <= mem_wen;
        end
        if (busy) begin
            assert (mem_req && mem_addr == held_addr && mem_wen == held_wen)
                else $error("vmem_lsc: request dropped or changed before mem_ready");
        end
    end

endmodule

/* hw/vmem_unit.sv */
// Top level of the four-lane vector memory unit with micro-op and data port connections
`timescale 1ns/1ps

module vmem_unit (
    input  logic                                         CLK,
    input  logic                                         nRST,
    // Micro-op request
    input  logic                                         req_valid,
    output logic                                         req_ready,
    input  logic                                         req_store,
    input  logic                                         req_indexed,
    input  logic [vmem_pkg::UOP_W-1:0]                   req_uop_num,
    input  vmem_pkg::word_t                              req_base,
    input  vmem_pkg::word_t                              req_stride,
    input  vmem_pkg::word_t [vmem_pkg::NUM_LANES-1:0]    req_index,
    input  logic [vmem_pkg::NUM_LANES-1:0]               req_mask,
    input  vmem_pkg::sew_t                               req_eew,
    input  vmem_pkg::word_t [vmem_pkg::NUM_LANES-1:0]    req_store_data,
    // Response, one pulse per micro-op
    output logic                                         resp_valid,
    output vmem_pkg::word_t [vmem_pkg::NUM_LANES-1:0]    resp_load_data,
    // Data port
    output logic                                         mem_req,
    output logic                                         mem_wen,
    output vmem_pkg::word_t                              mem_addr,
    output logic [vmem_pkg::BYTES_W-1:0]                 mem_byte_en,
    output vmem_pkg::word_t                              mem_wdata,
    input  vmem_pkg::word_t                              mem_rdata,
    input  logic                                         mem_ready
);

    vmem_serial_if serial_if ();
    vmem_lsc_if    lsc_if ();

    vmem_sequencer sequencer_i (
        .CLK            (CLK),
        .nRST           (nRST),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req_store      (req_store),
        .req_indexed    (req_indexed),
        .req_uop_num    (req_uop_num),
        .req_base       (req_base),
        .req_stride     (req_stride),
        .req_index      (req_index),
        .req_mask       (req_mask),
        .req_eew        (req_eew),
        .req_store_data (req_store_data),
        .resp_valid     (resp_valid),
        .resp_load_data (resp_load_data),
        .serial_if      (serial_if.seq)
    );

    vmem_serializer serializer_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .serial_if (serial_if.serial),
        .lsc_if    (lsc_if.serial)
    );

    vmem_lsc lsc_i (
        .CLK         (CLK),
        .nRST        (nRST),
        .lsc_if      (lsc_if.lsc),
        .mem_req     (mem_req),
        .mem_wen     (mem_wen),
        .mem_addr    (mem_addr),
        .mem_byte_en (mem_byte_en),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata),
        .mem_ready   (mem_ready)
    );

endmodule

/* tb/vmem_mem_model.sv */
// Byte-addressed memory behind the vector unit data port, with optional random wait states
`timescale 1ns/1ps

module vmem_mem_model (
    input  logic                            CLK,
    input  logic                            nRST,
    input  logic                            wait_en,     // Random 0 to 3 wait states per access
    input  logic                            mem_req,
    input  logic                            mem_wen,
    input  vmem_pkg::word_t                 mem_addr,
    input  logic [vmem_pkg::BYTES_W-1:0]    mem_byte_en,
    input  vmem_pkg::word_t                 mem_wdata,
    output vmem_pkg::word_t                 mem_rdata,
    output logic                            mem_ready
);

    import vmem_pkg::*;

    logic [7:0]     mem [1024];      // Contents loaded by the testbench
    int unsigned    stall;           // Wait states left before the access completes
    int unsigned    next_stall;      // Wait states drawn for the following access
    logic [9:0]     word_idx;

    assign word_idx  = {mem_addr[9:2], 2'b00};
    assign mem_ready = mem_req && (stall == 0);
    assign mem_rdata = {mem[word_idx | 10'd3], mem[word_idx | 10'd2],
                        mem[word_idx | 10'd1], mem[word_idx]};

    // One seeded stream of wait-state draws
    initial begin
        void'($urandom(89060));
        forever begin
            @(posedge CLK);
            next_stall <= $urandom % 4;
        end
    end

    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            stall <= 0;
        end else if (mem_req && stall != 0) begin
            stall <= stall - 1;
        end else if (mem_ready) begin
            for (int b = 0; b < BYTES_W; b++) begin
                if (mem_wen && mem_byte_en[b])
                    mem[word_idx | 10'(b)] <= mem_wdata[8*b +: 8];
            end
            stall <= wait_en ? next_stall : 0;   // Used by the next access
        end
    end

endmodule

/* tb/vmem_unit_properties.sv */
// Concurrent handshake and lane-mask checks, bound into every vmem_unit instance
`timescale 1ns/1ps

module vmem_unit_properties (
    input logic                             CLK,
    input logic                             nRST,
    input logic                             req_valid,
    input logic                             req_ready,
    input logic [vmem_pkg::NUM_LANES-1:0]   req_mask,
    input logic                             resp_valid,
    input logic                             mem_req,
    input logic                             mem_wen,
    input logic                             mem_ready,
    input vmem_pkg::word_t                  mem_addr,
    input vmem_pkg::serial_state_t          lane_state
);

    import vmem_pkg::*;

    int unsigned            fail_count = 0;
    logic [NUM_LANES-1:0]   mask_q;       // Lane mask of the accepted micro-op
    logic                   in_flight;    // Accepted micro-op not yet answered

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            mask_q    <= '0;
            in_flight <= 1'b0;
        end else if (req_valid && req_ready) begin
            mask_q    <= req_mask;
            in_flight <= 1'b1;
        end else if (resp_valid) begin
            in_flight <= 1'b0;
        end
    end

    // Data port request waits with a fixed address and direction
    req_held: assert property (@(posedge CLK) disable iff (!nRST)
        mem_req && !mem_ready |=> mem_req && $stable(mem_addr) && $stable(mem_wen))
        else begin
            fail_count++;
            $error("Data port request changed before mem_ready");
        end

    resp_idle: assert property (@(posedge CLK) disable iff (!nRST)
        resp_valid |-> in_flight && req_ready)   // One response per micro-op, back in idle
        else begin
            fail_count++;
            $error("Response without a micro-op in flight or while not ready");
        end

    // No data port access for a lane that is masked off
    masked_quiet: assert property (@(posedge CLK) disable iff (!nRST)
        mem_req |-> mask_q[lane_state])
        else begin
            fail_count++;
            $error("Data port access for a masked lane");
        end

endmodule

bind vmem_unit vmem_unit_properties props_i (
    .CLK        (CLK),
    .nRST       (nRST),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req_mask   (req_mask),
    .resp_valid (resp_valid),
    .mem_req    (mem_req),
    .mem_wen    (mem_wen),
    .mem_ready  (mem_ready),
    .mem_addr   (mem_addr),
    .lane_state (serializer_i.serial_state)
);

/* tb/vmem_unit_tb.sv */
// Directed testbench for the vector memory unit; expected values come from a byte copy of memory
`timescale 1ns/1ps

module vmem_unit_tb;

    import vmem_pkg::*;

    localparam int MEM_BYTES      = 1024;
    localparam int TIMEOUT_CYCLES = 2000;   // Ten micro-ops of under 25 cycles each, wide margin

    logic                   CLK = 1'b0;
    logic                   nRST;
    logic                   req_valid;
    logic                   req_ready;
    logic                   req_store;
    logic                   req_indexed;
    logic [UOP_W-1:0]       req_uop_num;
    word_t                  req_base;
    word_t                  req_stride;
    word_t [NUM_LANES-1:0]  req_index;
    logic [NUM_LANES-1:0]   req_mask;
    sew_t                   req_eew;
    word_t [NUM_LANES-1:0]  req_store_data;
    logic                   resp_valid;
    word_t [NUM_LANES-1:0]  resp_load_data;
    logic                   mem_req;
    logic                   mem_wen;
    word_t                  mem_addr;
    logic [BYTES_W-1:0]     mem_byte_en;
    word_t                  mem_wdata;
    word_t                  mem_rdata;
    logic                   mem_ready;
    logic                   wait_en;
    logic [7:0]             exp_mem [MEM_BYTES];   // Expected memory contents
    int                     cycle_count = 0;

    vmem_unit dut_i (.*);
    vmem_mem_model mem_i (.*);

    always #10 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
            stop_with_failure($sformatf("Timeout, no result after %0d cycles", cycle_count));
    end

    always @(negedge CLK) begin
        if (dut_i.props_i.fail_count != 0)
            stop_with_failure("A bound handshake or lane-mask assertion failed");
    end

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("Result: FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    function automatic logic [7:0] fill_byte(input int a);
        return 8'(a * 7 + (a >> 4) * 13) ^ 8'h3c;
    endfunction

    // Sends one micro-op, waits for its response and checks lanes and memory
    task automatic run_uop(input logic store, input logic indexed, input int uop,
                           input word_t base, input word_t stride,
                           input word_t [NUM_LANES-1:0] index, input logic [NUM_LANES-1:0] mask,
                           input sew_t eew, input word_t [NUM_LANES-1:0] sdata);
        word_t addr;
        word_t expected;
        int    nbytes;
        nbytes = (eew == SEW8) ? 1 : (eew == SEW16) ? 2 : 4;
        @(posedge CLK);
        req_valid      <= 1'b1;
        req_store      <= store;
        req_indexed    <= indexed;
        req_uop_num    <= UOP_W'(uop);
        req_base       <= base;
        req_stride     <= stride;
        req_index      <= index;
        req_mask       <= mask;
        req_eew        <= eew;
        req_store_data <= sdata;
        @(negedge CLK);
        while (!req_ready) @(negedge CLK);
        @(posedge CLK);
        req_valid <= 1'b0;   // Accepted at this edge
        @(negedge CLK);
        while (!resp_valid) @(negedge CLK);
        assert (req_ready) else stop_with_failure("req_ready did not rise with resp_valid");
        for (int i = 0; i < NUM_LANES; i++) begin
            // Strided micro-op n continues at lane 4n
            addr     = indexed ? base + index[i] : base + (uop * NUM_LANES + i) * stride;
            expected = '0;
            for (int b = 0; b < nbytes; b++) begin
                if (store && mask[i])
                    exp_mem[10'(addr + b)] = sdata[i][8*b +: 8];
                expected[8*b +: 8] = exp_mem[10'(addr + b)];
            end
            if (store || !mask[i])
                expected = '0;
            assert (resp_load_data[i] == expected) else stop_with_failure($sformatf(
                "[FAIL] %0t: lane %0d at %h returned %h, expected %h",
                $time, i, addr, resp_load_data[i], expected));
        end
        for (int a = 0; a < MEM_BYTES; a++) begin
            assert (mem_i.mem[a] == exp_mem[a]) else stop_with_failure($sformatf(
                "[FAIL] %0t: memory byte %h is %h, expected %h", $time, a, mem_i.mem[a], exp_mem[a]));
        end
    endtask

    task automatic check_reset_state();
        @(negedge CLK);
        assert (req_ready && !resp_valid && !mem_req) else stop_with_failure($sformatf(
            "[FAIL] %0t: after reset req_ready %b resp_valid %b mem_req %b",
            $time, req_ready, resp_valid, mem_req));
    endtask

    task automatic test_unit_stride_load();
        run_uop(1'b0, 1'b0, 0, 32'h40, 32'd4, '0, 4'b1111, SEW32, '0);
    endtask

    task automatic test_narrow_strided();
        word_t [NUM_LANES-1:0] sdata;
        sdata = {32'h1234_56f1, 32'h0bad_c0e2, 32'h7777_88d3, 32'hcafe_9a04};
        run_uop(1'b1, 1'b0, 0, 32'h100, 32'd3, '0, 4'b1111, SEW8, sdata);
        run_uop(1'b1, 1'b0, 0, 32'h140, 32'd6, '0, 4'b1111, SEW16, sdata);
        run_uop(1'b0, 1'b0, 0, 32'h100, 32'd3, '0, 4'b1111, SEW8, '0);
        run_uop(1'b0, 1'b0, 0, 32'h140, 32'd6, '0, 4'b1111, SEW16, '0);
    endtask

    task automatic test_uop_continuation();
        run_uop(1'b0, 1'b0, 0, 32'h200, 32'd8, '0, 4'b1111, SEW32, '0);
        run_uop(1'b0, 1'b0, 1, 32'h200, 32'd8, '0, 4'b1111, SEW32, '0);
    endtask

    task automatic test_indexed_load();
        run_uop(1'b0, 1'b1, 0, 32'h300, 32'd0, {32'h10, 32'h30, 32'h04, 32'h1c},
                4'b1111, SEW32, '0);
    endtask

    task automatic test_masked_with_waits();
        word_t [NUM_LANES-1:0] sdata;
        sdata = {32'h3333_0003, 32'h2222_0002, 32'h1111_0001, 32'h0000_5a5a};
        wait_en <= 1'b1;
        run_uop(1'b1, 1'b0, 0, 32'h380, 32'd4, '0, 4'b1010, SEW32, sdata);
        run_uop(1'b0, 1'b0, 0, 32'h380, 32'd4, '0, 4'b1010, SEW32, '0);
        wait_en <= 1'b0;
    endtask

    initial begin
        nRST           = 1'b0;
        req_valid      = 1'b0;
        req_store      = 1'b0;
        req_indexed    = 1'b0;
        req_uop_num    = '0;
        req_base       = '0;
        req_stride     = '0;
        req_index      = '0;
        req_mask       = '0;
        req_eew        = SEW32;
        req_store_data = '0;
        wait_en        = 1'b0;
        for (int a = 0; a < MEM_BYTES; a++) begin
            exp_mem[a]   = fill_byte(a);
            mem_i.mem[a] = exp_mem[a];
        end
        repeat (2) @(posedge CLK);
        nRST <= 1'b1;
        check_reset_state();
        test_unit_stride_load();
        test_narrow_strided();
        test_uop_continuation();
        test_indexed_load();
        test_masked_with_waits();
        if (dut_i.props_i.fail_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

/* sources.f */
hw/vmem_pkg.sv
hw/vmem_serial_if.sv
hw/vmem_lsc_if.sv
hw/vmem_sequencer.sv
hw/vmem_serializer.sv
hw/vmem_lsc.sv
hw/vmem_unit.sv
tb/vmem_mem_model.sv
tb/vmem_unit_properties.sv
tb/vmem_unit_tb.sv
